// File: design/fmPkg.sv
package fmPkg;

    // ------------------------------------------------------------
    // Slot geometry
    // ------------------------------------------------------------
    localparam int NumVoices    = 16;
    localparam int NumOperators = 6;
    localparam int NumSlots     = NumVoices * NumOperators;

    // Fetch at t, scaled amplitude at t+4
    localparam int PipeLatency  = 5;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    typedef enum logic [1:0] {WaveOff, WaveSquare, WaveSaw} waveType_t;

    typedef enum logic [1:0] {AlgoChain, AlgoParallel, AlgoPairs, AlgoStack} algo_t;

    // Bus opcode, address bits 9:8
    typedef enum logic [1:0] {FieldStep, FieldLevel, FieldWave, FieldVoice} cfgField_t;

    // ------------------------------------------------------------
    // Configuration and pipeline words
    // ------------------------------------------------------------
    typedef struct packed {
        logic [15:0] phaseStep;
        logic [14:0] level;
        waveType_t   wave;
    } operatorCfg_t;

    // Bit 0 is keyOn, bits 2:1 the algorithm
    typedef struct packed {
        algo_t algo;
        logic  keyOn;
    } voiceCfg_t;

    // Routing control, travels alongside the amplitude
    typedef struct packed {
        logic [3:0] voice;
        logic       modLoad;
        logic       modAccum;
        logic       carrier;
        logic       frameEnd;
    } opCtrl_t;

    typedef struct packed {
        logic [15:0] phase;
        logic [14:0] level;
        waveType_t   wave;
    } phaseStage_t;

    // ------------------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------------------
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [9:0]  adr;
        logic [15:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wbRsp_t;

endpackage

// File: design/slotSequencer.sv
`timescale 1ns/1ns

module slotSequencer (
    input  logic             i_Clock,
    input  logic             i_rstN,
    input  fmPkg::voiceCfg_t i_VoiceCfg,
    output logic [6:0]       o_Slot,
    output logic [3:0]       o_Voice,
    output logic             o_ModUse,
    output fmPkg::opCtrl_t   o_OpCtrl
);
    import fmPkg::*;

    logic [6:0] slotCount;
    logic [2:0] opIndex;
    opCtrl_t    ctrlNow;
    // Stage i holds the control of the slot fetched i cycles ago
    opCtrl_t    ctrlPipe [1:PipeLatency-1];

    // Slot = operator * 16 + voice
    assign opIndex = slotCount[6:4];
    assign o_Slot  = slotCount;
    assign o_Voice = slotCount[3:0];

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            slotCount <= '0;
        end else if (slotCount == 7'(NumSlots - 1)) begin
            slotCount <= '0;
        end else begin
            slotCount <= slotCount + 7'd1;
        end
    end

    // ------------------------------------------------------------
    // Algorithm decode
    // ------------------------------------------------------------
    always_comb begin
        ctrlNow          = '0;
        ctrlNow.voice    = slotCount[3:0];
        ctrlNow.frameEnd = (slotCount == 7'(NumSlots - 1));
        o_ModUse         = 1'b0;
        case (i_VoiceCfg.algo)
            AlgoChain: begin
                // Each operator modulates the next one
                ctrlNow.modLoad = (opIndex <= 3'd4);
                o_ModUse        = (opIndex >= 3'd1);
                ctrlNow.carrier = (opIndex == 3'd5);
            end
            AlgoParallel: begin
                ctrlNow.carrier = 1'b1;
            end
            AlgoPairs: begin
                // Even operator drives the odd one above it
                ctrlNow.modLoad = ~opIndex[0];
                o_ModUse        = opIndex[0];
                ctrlNow.carrier = opIndex[0];
            end
            AlgoStack: begin
                // Operators 0 to 4 sum into M, operator 5 hears them all
                ctrlNow.modLoad  = (opIndex == 3'd0);
                ctrlNow.modAccum = (opIndex >= 3'd1) && (opIndex <= 3'd4);
                o_ModUse         = (opIndex == 3'd5);
                ctrlNow.carrier  = (opIndex == 3'd5);
            end
            default: ;
        endcase
    end

    // Delay line, output lines up with the amplitude at t+4
    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 1; i < PipeLatency; i++) begin
                ctrlPipe[i] <= '0;
            end
        end else begin
            ctrlPipe[1] <= ctrlNow;
            for (int i = 2; i < PipeLatency; i++) begin
                ctrlPipe[i] <= ctrlPipe[i-1];
            end
        end
    end

    assign o_OpCtrl = ctrlPipe[PipeLatency-1];

    // Counter wraps at 95
    slotInRange: assert property (@(posedge i_Clock) disable iff (!i_rstN)
        slotCount < 7'(NumSlots))
        else $error("slot counter left the frame");

endmodule

// File: design/configRegs.sv
`timescale 1ns/1ns

module configRegs (
    input  logic                i_Clock,
    input  logic                i_rstN,
    input  fmPkg::wbReq_t       i_Wb,
    input  logic [6:0]          i_Slot,
    input  logic [3:0]          i_Voice,
    output fmPkg::wbRsp_t       o_Wb,
    output fmPkg::operatorCfg_t o_OperatorCfg,
    output fmPkg::voiceCfg_t    o_VoiceCfg
);
    import fmPkg::*;

    operatorCfg_t opCfg    [NumSlots];
    voiceCfg_t    voiceCfg [NumVoices];

    cfgField_t   field;
    logic [6:0]  index;
    logic        slotValid;
    logic        voiceValid;
    logic        wbAck;
    logic        access;
    logic [15:0] rdMux;
    logic [15:0] rdData;

    // Synthesis side, read in the fetch cycle
    assign o_OperatorCfg = opCfg[i_Slot];
    assign o_VoiceCfg    = voiceCfg[i_Voice];

    // ------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------
    assign field      = cfgField_t'(i_Wb.adr[9:8]);
    assign index      = i_Wb.adr[6:0];
    assign slotValid  = (index < 7'(NumSlots));
    assign voiceValid = (index < 7'(NumVoices));
    // Taken once, the cycle after ack is a gap
    assign access     = i_Wb.cyc && i_Wb.stb && !wbAck;

    always_comb begin
        rdMux = '0;
        case (field)
            FieldStep:  if (slotValid)  rdMux = opCfg[index].phaseStep;
            FieldLevel: if (slotValid)  rdMux = {1'b0, opCfg[index].level};
            FieldWave:  if (slotValid)  rdMux = {14'b0, opCfg[index].wave};
            FieldVoice: if (voiceValid) rdMux = {13'b0, voiceCfg[index[3:0]]};
            default: ;
        endcase
    end

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < NumSlots; i++) begin
                opCfg[i] <= '0;
            end
            for (int i = 0; i < NumVoices; i++) begin
                voiceCfg[i] <= '0;
            end
            wbAck  <= 1'b0;
            rdData <= '0;
        end else begin
            wbAck <= access;
            if (access) begin
                rdData <= rdMux;
            end
            // Out-of-range writes fall through silently
            if (access && i_Wb.we) begin
                case (field)
                    FieldStep:  if (slotValid) opCfg[index].phaseStep <= i_Wb.dat;
                    FieldLevel: if (slotValid) opCfg[index].level <= i_Wb.dat[14:0];
                    FieldWave:  if (slotValid) opCfg[index].wave <= waveType_t'(i_Wb.dat[1:0]);
                    FieldVoice: begin
                        if (voiceValid) voiceCfg[index[3:0]] <= voiceCfg_t'(i_Wb.dat[2:0]);
                    end
                    default: ;
                endcase
            end
        end
    end

    assign o_Wb.ack = wbAck;
    assign o_Wb.dat = rdData;

    ackNeedsRequest: assert property (@(posedge i_Clock) disable iff (!i_rstN)
        $rose(wbAck) |-> $past(i_Wb.cyc && i_Wb.stb))
        else $error("ack without a bus request");

endmodule

// File: design/phaseGenerator.sv
`timescale 1ns/1ns

module phaseGenerator (
    input  logic                i_Clock,
    input  logic                i_rstN,
    input  logic [6:0]          i_Slot,
    input  fmPkg::operatorCfg_t i_OperatorCfg,
    input  logic                i_KeyOn,
    input  logic                i_ModUse,
    input  logic signed [15:0]  i_ModPhase,
    output fmPkg::phaseStage_t  o_Stage
);
    import fmPkg::*;

    // One accumulator per slot, visited once per frame
    logic [15:0] phaseAcc [NumSlots];
    logic [15:0] accNow;
    logic [15:0] modTerm;

    assign accNow  = phaseAcc[i_Slot];
    // Modulation offsets the output only, the accumulator stays clean
    assign modTerm = i_ModUse ? i_ModPhase : 16'sd0;

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < NumSlots; i++) begin
                phaseAcc[i] <= '0;
            end
            o_Stage <= '0;
        end else begin
            o_Stage.wave <= i_OperatorCfg.wave;
            if (i_KeyOn) begin
                phaseAcc[i_Slot] <= accNow + i_OperatorCfg.phaseStep;
                o_Stage.phase    <= accNow + modTerm;
                o_Stage.level    <= i_OperatorCfg.level;
            end else begin
                // Key off, phase parked at zero and silent
                phaseAcc[i_Slot] <= '0;
                o_Stage.phase    <= '0;
                o_Stage.level    <= '0;
            end
        end
    end

endmodule

// File: design/waveShaper.sv
`timescale 1ns/1ns

module waveShaper (
    input  logic               i_Clock,
    input  logic               i_rstN,
    input  fmPkg::phaseStage_t i_Stage,
    output logic signed [15:0] o_Amplitude
);
    import fmPkg::*;

    logic signed [15:0] rawNext;
    logic signed [15:0] rawWave;
    logic [14:0]        levelD1;
    logic signed [31:0] product;

    // ------------------------------------------------------------
    // Waveform select
    // ------------------------------------------------------------
    always_comb begin
        case (i_Stage.wave)
            // First half cycle high
            WaveSquare: rawNext = i_Stage.phase[15] ? -16'sd32767 : 16'sd32767;
            // Offset binary to two's complement
            WaveSaw:    rawNext = {~i_Stage.phase[15], i_Stage.phase[14:0]};
            default:    rawNext = '0;
        endcase
    end

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            rawWave     <= '0;
            levelD1     <= '0;
            product     <= '0;
            o_Amplitude <= '0;
        end else begin
            // Stage 1, raw wave at t+2
            rawWave <= rawNext;
            levelD1 <= i_Stage.level;
            // Stage 2, product at t+3, level is unsigned
            product <= rawWave * $signed({1'b0, levelD1});
            // Stage 3, arithmetic shift by 15
            // Magnitude stays under 2^15 so bits 30:15 hold the whole result
            o_Amplitude <= product[30:15];
        end
    end

endmodule

// File: design/modulationRouter.sv
`timescale 1ns/1ns

module modulationRouter (
    input  logic               i_Clock,
    input  logic               i_rstN,
    input  logic signed [15:0] i_Amplitude,
    input  fmPkg::opCtrl_t     i_OpCtrl,
    input  logic [3:0]         i_Voice,
    output logic signed [15:0] o_ModPhase
);
    import fmPkg::*;

    // M register per voice
    logic signed [15:0] modReg [NumVoices];

    // Read for the voice being fetched now
    assign o_ModPhase = modReg[i_Voice];

    // ------------------------------------------------------------
    // Write side, driven by the delayed control at t+4
    // ------------------------------------------------------------
    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < NumVoices; i++) begin
                modReg[i] <= '0;
            end
        end else if (i_OpCtrl.modLoad) begin
            modReg[i_OpCtrl.voice] <= i_Amplitude;
        end else if (i_OpCtrl.modAccum) begin
            // Wraps like a phase offset
            modReg[i_OpCtrl.voice] <= modReg[i_OpCtrl.voice] + i_Amplitude;
        end
    end

    loadXorAccum: assert property (@(posedge i_Clock) disable iff (!i_rstN)
        !(i_OpCtrl.modLoad && i_OpCtrl.modAccum))
        else $error("load and accumulate together");

endmodule

// File: design/sampleMixer.sv
`timescale 1ns/1ns

module sampleMixer (
    input  logic               i_Clock,
    input  logic               i_rstN,
    input  logic signed [15:0] i_Amplitude,
    input  fmPkg::opCtrl_t     i_OpCtrl,
    output logic signed [15:0] o_Sample,
    output logic               o_SampleValid
);
    import fmPkg::*;

    // 96 full-scale carriers need 23 bits
    logic signed [23:0] frameSum;
    logic signed [23:0] addend;
    logic signed [20:0] scaled;
    logic               frameDone;

    assign addend = i_OpCtrl.carrier ? {{8{i_Amplitude[15]}}, i_Amplitude} : '0;
    assign scaled = frameSum[23:3];

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            frameSum      <= '0;
            frameDone     <= 1'b0;
            o_Sample      <= '0;
            o_SampleValid <= 1'b0;
        end else begin
            frameDone     <= i_OpCtrl.frameEnd;
            o_SampleValid <= frameDone;
            // Sum closes on slot 95, next slot starts a fresh frame
            frameSum <= frameDone ? addend : frameSum + addend;
            if (frameDone) begin
                if (scaled > 21'sd32767)       o_Sample <= 16'sd32767;
                else if (scaled < -21'sd32767) o_Sample <= -16'sd32767;
                else                           o_Sample <= scaled[15:0];
            end
        end
    end

endmodule

// File: design/fmCore.sv
`timescale 1ns/1ns

module fmCore (
    input  logic                i_Clock,
    input  logic                i_rstN,
    input  fmPkg::wbReq_t       i_Wb,
    output fmPkg::wbRsp_t       o_Wb,
    output logic signed [15:0]  o_Sample,
    output logic                o_SampleValid
);
    import fmPkg::*;

    // Fetch side, cycle t
    logic [6:0]         slot;
    logic [3:0]         voice;
    logic               modUse;
    operatorCfg_t       operatorCfg;
    voiceCfg_t          voiceCfg;
    logic signed [15:0] modPhase;

    // Pipeline side, phase at t+1, amplitude and control at t+4
    phaseStage_t        stage;
    logic signed [15:0] amplitude;
    opCtrl_t            opCtrl;

    slotSequencer u_slotSequencer (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_VoiceCfg (voiceCfg),
        .o_Slot     (slot),
        .o_Voice    (voice),
        .o_ModUse   (modUse),
        .o_OpCtrl   (opCtrl)
    );

    configRegs u_configRegs (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_Wb          (i_Wb),
        .i_Slot        (slot),
        .i_Voice       (voice),
        .o_Wb          (o_Wb),
        .o_OperatorCfg (operatorCfg),
        .o_VoiceCfg    (voiceCfg)
    );

    phaseGenerator u_phaseGenerator (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_Slot        (slot),
        .i_OperatorCfg (operatorCfg),
        .i_KeyOn       (voiceCfg.keyOn),
        .i_ModUse      (modUse),
        .i_ModPhase    (modPhase),
        .o_Stage       (stage)
    );

    waveShaper u_waveShaper (
        .i_Clock     (i_Clock),
        .i_rstN      (i_rstN),
        .i_Stage     (stage),
        .o_Amplitude (amplitude)
    );

    modulationRouter u_modulationRouter (
        .i_Clock     (i_Clock),
        .i_rstN      (i_rstN),
        .i_Amplitude (amplitude),
        .i_OpCtrl    (opCtrl),
        .i_Voice     (voice),
        .o_ModPhase  (modPhase)
    );

    sampleMixer u_sampleMixer (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_Amplitude   (amplitude),
        .i_OpCtrl      (opCtrl),
        .o_Sample      (o_Sample),
        .o_SampleValid (o_SampleValid)
    );

endmodule

// File: include/fmTbTasks.svh
`ifndef FM_TB_TASKS_SVH
`define FM_TB_TASKS_SVH

// ------------------------------------------------------------
// Typed compares
// ------------------------------------------------------------
task automatic checkSample(input string name, input logic signed [15:0] expected,
                           input logic signed [15:0] actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

task automatic checkWbData(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("MISMATCH at %0t ns: %s expected 0x%04h, got 0x%04h",
                 $time, name, expected, actual);
    end
endtask

task automatic checkPeriod(input string name, input int expected, input int actual);
    checkCount++;
    if (actual != expected) begin
        errorCount++;
        $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
        $display("Test %s: ok", name);
    end else begin
        testFailCount++;
        $display("Test %s: %0d errors", name, errorCount - errorsBefore);
    end
endtask

// ------------------------------------------------------------
// Reference model
// ------------------------------------------------------------
function automatic int waveValue(input waveType_t wave, input logic [15:0] phase);
    case (wave)
        WaveSquare: return phase[15] ? -32767 : 32767;
        // Offset binary read as two's complement
        WaveSaw:    return int'($signed(phase ^ 16'h8000));
        default:    return 0;
    endcase
endfunction

function automatic int scaleLevel(input int raw, input logic [14:0] level);
    return (raw * int'(level)) >>> 15;
endfunction

function automatic logic signed [15:0] mixSample(input int frameSum);
    int scaled;
    scaled = frameSum >>> 3;
    if (scaled > 32767) begin
        return 16'sd32767;
    end else if (scaled < -32767) begin
        return -16'sd32767;
    end else begin
        return 16'(scaled);
    end
endfunction

// Carrier sum of one voice, every accumulator sitting at basePhase
function automatic int voiceCarrierSum(input algo_t algo, input logic [15:0] basePhase);
    logic [5:0]  loadMask;
    logic [5:0]  accumMask;
    logic [5:0]  useMask;
    logic [5:0]  carrierMask;
    logic [15:0] modValue;
    logic [15:0] phase;
    int          amp;
    int          sum;
    // Routing table, bit n is operator n
    case (algo)
        AlgoChain: begin
            loadMask    = 6'b011111;
            accumMask   = 6'b000000;
            useMask     = 6'b111110;
            carrierMask = 6'b100000;
        end
        AlgoPairs: begin
            loadMask    = 6'b010101;
            accumMask   = 6'b000000;
            useMask     = 6'b101010;
            carrierMask = 6'b101010;
        end
        AlgoStack: begin
            loadMask    = 6'b000001;
            accumMask   = 6'b011110;
            useMask     = 6'b100000;
            carrierMask = 6'b100000;
        end
        default: begin
            loadMask    = 6'b000000;
            accumMask   = 6'b000000;
            useMask     = 6'b000000;
            carrierMask = 6'b111111;
        end
    endcase
    modValue = '0;
    sum      = 0;
    for (int op = 0; op < NumOperators; op++) begin
        phase = useMask[op] ? basePhase + modValue : basePhase;
        amp   = scaleLevel(waveValue(opWave[op], phase), opLevel[op]);
        if (loadMask[op]) begin
            modValue = 16'(amp);
        end else if (accumMask[op]) begin
            modValue = modValue + 16'(amp);
        end
        if (carrierMask[op]) begin
            sum += amp;
        end
    end
    return sum;
endfunction

// ------------------------------------------------------------
// Configuration helpers
// ------------------------------------------------------------
task automatic setVoice(input int voice, input algo_t algo, input logic keyOn);
    wbWrite(FieldVoice, voice, {13'b0, algo, keyOn});
endtask

// Writes opWave and opLevel into the six slots of one voice
task automatic loadVoice(input int voice, input logic [15:0] step);
    int slot;
    for (int op = 0; op < NumOperators; op++) begin
        slot = op * NumVoices + voice;
        wbWrite(FieldStep, slot, step);
        wbWrite(FieldLevel, slot, {1'b0, opLevel[op]});
        wbWrite(FieldWave, slot, {14'b0, opWave[op]});
    end
endtask

// Key off first, far more than one frame of writes parks every phase at zero
task automatic clearAll;
    for (int v = 0; v < NumVoices; v++) begin
        setVoice(v, AlgoChain, 1'b0);
    end
    for (int s = 0; s < NumSlots; s++) begin
        wbWrite(FieldStep, s, 16'h0000);
        wbWrite(FieldLevel, s, 16'h0000);
        wbWrite(FieldWave, s, 16'h0000);
    end
endtask

// Frame in progress, the frame it may have split, then one clean frame
task automatic settle;
    repeat (3) waitSample();
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic testRegisterAccess;
    int          errorsBefore;
    int          slot;
    int          voice;
    logic [15:0] data [4];
    logic [15:0] readBack;
    errorsBefore = errorCount;
    slot  = {$random(seed)} % NumSlots;
    voice = {$random(seed)} % NumVoices;
    for (int i = 0; i < 4; i++) begin
        data[i] = 16'($random(seed));
    end
    wbWrite(FieldStep, slot, data[0]);
    wbWrite(FieldLevel, slot, data[1]);
    wbWrite(FieldWave, slot, data[2]);
    wbWrite(FieldVoice, voice, data[3]);
    wbRead(FieldStep, slot, readBack);
    checkWbData("step", data[0], readBack);
    wbRead(FieldLevel, slot, readBack);
    checkWbData("level", {1'b0, data[1][14:0]}, readBack);
    wbRead(FieldWave, slot, readBack);
    checkWbData("wave", {14'b0, data[2][1:0]}, readBack);
    wbRead(FieldVoice, voice, readBack);
    checkWbData("voice", {13'b0, data[3][2:0]}, readBack);
    // ack must be gone one cycle after it was seen
    @(posedge clock);
    #DriveDelay;
    checkCount++;
    if (wbRsp.ack) begin
        errorCount++;
        $display("ERROR at %0t ns: ack stayed high longer than one cycle", $time);
    end
    // Beyond the last slot and voice
    wbWrite(FieldStep, 100, 16'hBEEF);
    wbRead(FieldStep, 100, readBack);
    checkWbData("step[100]", 16'h0000, readBack);
    wbWrite(FieldVoice, 20, 16'h0007);
    wbRead(FieldVoice, 20, readBack);
    checkWbData("voice[20]", 16'h0000, readBack);
    finishTest("register access", errorsBefore);
endtask

task automatic testResetTiming;
    int errorsBefore;
    int gap;
    errorsBefore = errorCount;
    // Full-level square carrier on slot 0, so reset has a live sample to clear
    wbWrite(FieldLevel, 0, 16'h7FFF);
    wbWrite(FieldWave, 0, {14'b0, WaveSquare});
    setVoice(0, AlgoParallel, 1'b1);
    settle();
    applyReset();
    checkSample("o_Sample", 16'sd0, sample);
    waitSample();
    for (int n = 0; n < 3; n++) begin
        gap = 0;
        do begin
            @(posedge clock);
            #DriveDelay;
            gap++;
        end while (!sampleValid && gap < SampleTimeout);
        checkPeriod("o_SampleValid period", NumSlots, gap);
    end
    finishTest("reset and frame timing", errorsBefore);
endtask

task automatic testParallelSquare;
    int errorsBefore;
    int voice;
    errorsBefore = errorCount;
    clearAll();
    voice = {$random(seed)} % NumVoices;
    for (int op = 0; op < NumOperators; op++) begin
        opWave[op]  = WaveSquare;
        opLevel[op] = 15'($random(seed));
    end
    loadVoice(voice, 16'h0000);
    setVoice(voice, AlgoParallel, 1'b1);
    settle();
    checkSample("o_Sample", mixSample(voiceCarrierSum(AlgoParallel, 16'h0000)), sample);
    setVoice(voice, AlgoParallel, 1'b0);
    settle();
    checkSample("o_Sample", 16'sd0, sample);
    finishTest("parallel square", errorsBefore);
endtask

task automatic testPhaseStepping;
    int                 errorsBefore;
    int                 voice;
    logic               expectHigh;
    logic signed [15:0] highValue;
    logic signed [15:0] lowValue;
    errorsBefore = errorCount;
    clearAll();
    voice = {$random(seed)} % NumVoices;
    for (int op = 0; op < NumOperators; op++) begin
        opWave[op]  = WaveOff;
        opLevel[op] = '0;
    end
    // Single carrier on operator 3, level kept large so both halves differ
    opWave[3]  = WaveSquare;
    opLevel[3] = 15'h4000 | 15'($random(seed));
    loadVoice(voice, 16'h8000);
    setVoice(voice, AlgoParallel, 1'b1);
    settle();
    highValue  = mixSample(voiceCarrierSum(AlgoParallel, 16'h0000));
    lowValue   = mixSample(voiceCarrierSum(AlgoParallel, 16'h8000));
    expectHigh = (sample == highValue);
    if (!expectHigh) begin
        checkSample("o_Sample", lowValue, sample);
    end
    repeat (4) begin
        waitSample();
        expectHigh = !expectHigh;
        checkSample("o_Sample", expectHigh ? highValue : lowValue, sample);
    end
    finishTest("phase stepping", errorsBefore);
endtask

task automatic testModulation;
    int    errorsBefore;
    int    voice;
    algo_t algoList [3];
    errorsBefore = errorCount;
    algoList = '{AlgoChain, AlgoStack, AlgoPairs};
    clearAll();
    voice = {$random(seed)} % NumVoices;
    opWave[0]  = WaveSquare;
    opLevel[0] = 15'($random(seed));
    for (int op = 1; op < NumOperators; op++) begin
        opWave[op]  = WaveSaw;
        opLevel[op] = 15'($random(seed));
    end
    loadVoice(voice, 16'h0000);
    foreach (algoList[i]) begin
        setVoice(voice, algoList[i], 1'b1);
        settle();
        checkSample("o_Sample", mixSample(voiceCarrierSum(algoList[i], 16'h0000)), sample);
    end
    finishTest("modulation", errorsBefore);
endtask

task automatic testSaturation;
    int errorsBefore;
    errorsBefore = errorCount;
    clearAll();
    for (int op = 0; op < NumOperators; op++) begin
        opWave[op]  = WaveSquare;
        opLevel[op] = 15'h7FFF;
    end
    for (int v = 0; v < NumVoices; v++) begin
        loadVoice(v, 16'h0000);
    end
    for (int v = 0; v < NumVoices; v++) begin
        setVoice(v, AlgoParallel, 1'b1);
    end
    settle();
    checkSample("o_Sample",
                mixSample(NumVoices * voiceCarrierSum(AlgoParallel, 16'h0000)), sample);
    // Step 0x8000 held for exactly one frame, so each slot advances once
    for (int s = 0; s < NumSlots; s++) begin
        wbWrite(FieldStep, s, 16'h8000);
        idleCycles(NumSlots - 1);
        wbWrite(FieldStep, s, 16'h0000);
    end
    settle();
    checkSample("o_Sample",
                mixSample(NumVoices * voiceCarrierSum(AlgoParallel, 16'h8000)), sample);
    finishTest("saturation", errorsBefore);
endtask

`endif

// File: dv/fmCoreTb.sv
`timescale 1ns/1ns

module fmCoreTb;
    import fmPkg::*;

    localparam int ClockHalf     = 10;
    localparam int DriveDelay    = 2;
    localparam int ResetCycles   = 5;
    localparam int AckTimeout    = 20;
    localparam int SampleTimeout = 3 * NumSlots;

    logic               clock;
    logic               rstN;
    wbReq_t             wbReq;
    wbRsp_t             wbRsp;
    logic signed [15:0] sample;
    logic               sampleValid;

    integer seed;
    int     errorCount;
    int     checkCount;
    int     testCount;
    int     testFailCount;

    // Operator setup of the voice under test, shared with the model
    waveType_t   opWave  [NumOperators];
    logic [14:0] opLevel [NumOperators];

    fmCore dut_i (
        .i_Clock       (clock),
        .i_rstN        (rstN),
        .i_Wb          (wbReq),
        .o_Wb          (wbRsp),
        .o_Sample      (sample),
        .o_SampleValid (sampleValid)
    );

    // 50 MHz
    always #ClockHalf clock = ~clock;

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------
    task automatic abortRun(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic applyReset;
        rstN  = 1'b0;
        wbReq = '0;
        repeat (ResetCycles) @(posedge clock);
        #DriveDelay;
        rstN = 1'b1;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) @(posedge clock);
        #DriveDelay;
    endtask

    // ------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------
    task automatic wbAccess(input logic we, input cfgField_t field, input int index,
                            input logic [15:0] wdata, output logic [15:0] rdata);
        int waitCycles;
        wbReq.cyc  = 1'b1;
        wbReq.stb  = 1'b1;
        wbReq.we   = we;
        // Bit 7 unused, bits 6:0 slot or voice
        wbReq.adr  = {field, 1'b0, 7'(index)};
        wbReq.dat  = wdata;
        waitCycles = 0;
        do begin
            @(posedge clock);
            #DriveDelay;
            waitCycles++;
        end while (!wbRsp.ack && waitCycles < AckTimeout);
        if (!wbRsp.ack) begin
            abortRun("Wishbone access got no ack");
        end else begin
            rdata = wbRsp.dat;
            wbReq = '0;
        end
    endtask

    task automatic wbWrite(input cfgField_t field, input int index, input logic [15:0] data);
        logic [15:0] unused;
        wbAccess(1'b1, field, index, data, unused);
    endtask

    task automatic wbRead(input cfgField_t field, input int index, output logic [15:0] data);
        wbAccess(1'b0, field, index, 16'h0000, data);
    endtask

    // Loops until the strobe, leaves the sample stable for reading
    task automatic waitSample;
        int waitCycles;
        waitCycles = 0;
        do begin
            @(posedge clock);
            #DriveDelay;
            waitCycles++;
        end while (!sampleValid && waitCycles < SampleTimeout);
        if (!sampleValid) begin
            abortRun("o_SampleValid did not pulse in time");
        end
    endtask

    `include "fmTbTasks.svh"

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        seed          = 46;
        clock         = 1'b0;
        rstN          = 1'b0;
        wbReq         = '0;
        errorCount    = 0;
        checkCount    = 0;
        testCount     = 0;
        testFailCount = 0;
        applyReset();

        testRegisterAccess();
        testResetTiming();
        testParallelSquare();
        testPhaseStepping();
        testModulation();
        testSaturation();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, testFailCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
design/fmPkg.sv
design/slotSequencer.sv
design/configRegs.sv
design/phaseGenerator.sv
design/waveShaper.sv
design/modulationRouter.sv
design/sampleMixer.sv
design/fmCore.sv
dv/fmCoreTb.sv

// File: run.sh
#!/bin/sh
# Build the fmCore testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module fmCoreTb -f flist.f -o fmCoreSim

./obj_dir/fmCoreSim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
echo "Simulation finished cleanly"
